/* source/pipe_pkg.sv */
// shared widths, types, RV32I opcode and function codes, ALU codes
// and data memory geometry
`default_nettype none

package pipe_pkg;

    localparam int XLEN = 32;

    // data word and register index
    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [2:0]      alu_op_t;

    // RV32I major opcodes of the subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // funct3 values
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    // word size for LW and SW
    localparam logic [2:0] F3_WORD    = 3'b010;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    // funct7 selecting SUB over ADD
    localparam logic [6:0] F7_SUB = 7'b0100000;

    // ALU operation codes
    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;
    localparam alu_op_t ALU_SLT = 3'd5;

    // data memory, word addressed
    localparam int DMEM_WORDS = 64;
    localparam int DMEM_AW    = 6;

    localparam word_t RESET_PC = '0;

endpackage : pipe_pkg

`default_nettype wire

/* source/dep_hzrd_detection.sv */
// forwarding selects and data for EX, and the ID/EX flush
`default_nettype none

module dep_hzrd_detection (
    // unused, the unit is purely combinational
    input  logic                clk_i,
    input  logic                rst_n_i,
    // ID/EX sources
    input  pipe_pkg::reg_addr_t id_ex_rs1_addr_i,
    input  pipe_pkg::reg_addr_t id_ex_rs2_addr_i,
    // EX/MEM
    input  pipe_pkg::reg_addr_t ex_mem_rd_addr_i,
    input  logic                ex_mem_write_rd_i,
    input  logic                ex_mem_wb_use_mem_i,
    input  pipe_pkg::word_t     ex_mem_alu_result_i,
    // MEM/WB
    input  pipe_pkg::reg_addr_t mem_wb_rd_addr_i,
    input  logic                mem_wb_write_rd_i,
    input  logic                mem_wb_use_mem_i,
    input  pipe_pkg::word_t     mem_wb_alu_result_i,
    input  pipe_pkg::word_t     mem_wb_dmem_rdata_i,
    // IF/ID slot valid
    input  logic                instr_valid_i,
    input  logic                load_pc_i,
    output logic                forward_ex_mem_rs1_o,
    output logic                forward_ex_mem_rs2_o,
    output pipe_pkg::word_t     forward_ex_mem_data_o,
    output logic                forward_mem_wb_rs1_o,
    output logic                forward_mem_wb_rs2_o,
    output pipe_pkg::word_t     forward_mem_wb_data_o,
    output logic                id_ex_flush_o
);

    logic ex_mem_fwd_ok;
    logic mem_wb_fwd_ok;

    // a load in EX/MEM only holds the address, its data comes one stage later
    assign ex_mem_fwd_ok = (ex_mem_rd_addr_i != 5'd0) && ex_mem_write_rd_i &&
                           !ex_mem_wb_use_mem_i;
    assign mem_wb_fwd_ok = (mem_wb_rd_addr_i != 5'd0) && mem_wb_write_rd_i;

    // youngest producer first, so a chain on the same rd sees the latest value
    always_comb begin
        forward_ex_mem_rs1_o = 1'b0;
        forward_mem_wb_rs1_o = 1'b0;
        forward_ex_mem_rs2_o = 1'b0;
        forward_mem_wb_rs2_o = 1'b0;
        if (ex_mem_fwd_ok && (ex_mem_rd_addr_i == id_ex_rs1_addr_i))
            forward_ex_mem_rs1_o = 1'b1;
        else if (mem_wb_fwd_ok && (mem_wb_rd_addr_i == id_ex_rs1_addr_i))
            forward_mem_wb_rs1_o = 1'b1;
        if (ex_mem_fwd_ok && (ex_mem_rd_addr_i == id_ex_rs2_addr_i))
            forward_ex_mem_rs2_o = 1'b1;
        else if (mem_wb_fwd_ok && (mem_wb_rd_addr_i == id_ex_rs2_addr_i))
            forward_mem_wb_rs2_o = 1'b1;
    end

    assign forward_ex_mem_data_o = ex_mem_alu_result_i;
    // loaded word rather than its address
    assign forward_mem_wb_data_o = mem_wb_use_mem_i ? mem_wb_dmem_rdata_i : mem_wb_alu_result_i;

    // taken branch kills the decoded instruction, an empty slot becomes a bubble
    assign id_ex_flush_o = load_pc_i || !instr_valid_i;

endmodule : dep_hzrd_detection

`default_nettype wire

/* source/front_end_stage.sv */
// PC and IF/ID registers, decode, register file and ID/EX register
`default_nettype none

module front_end_stage (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  pipe_pkg::word_t     instr_i,
    input  logic                instr_valid_i,
    input  logic                load_pc_i,
    input  pipe_pkg::word_t     pc_target_i,
    input  logic                id_ex_flush_i,
    input  logic                wb_write_i,
    input  pipe_pkg::reg_addr_t wb_rd_i,
    input  pipe_pkg::word_t     wb_data_i,
    output pipe_pkg::word_t     pc_o,
    output logic                id_ex_valid_o,
    output pipe_pkg::reg_addr_t id_ex_rs1_addr_o,
    output pipe_pkg::reg_addr_t id_ex_rs2_addr_o,
    output pipe_pkg::word_t     id_ex_rs1_data_o,
    output pipe_pkg::word_t     id_ex_rs2_data_o,
    output pipe_pkg::reg_addr_t id_ex_rd_addr_o,
    output pipe_pkg::word_t     id_ex_imm_o,
    output pipe_pkg::word_t     id_ex_pc_o,
    output pipe_pkg::alu_op_t   id_ex_alu_op_o,
    output logic                id_ex_use_imm_o,
    output logic                id_ex_write_rd_o,
    output logic                id_ex_mem_read_o,
    output logic                id_ex_mem_write_o,
    output logic                id_ex_branch_o,
    output logic                id_ex_branch_ne_o,
    output logic                if_id_valid_o
);

    pipe_pkg::word_t     if_id_instr;
    pipe_pkg::word_t     if_id_pc;
    pipe_pkg::word_t     regs [32];
    pipe_pkg::word_t     imm_i, imm_s, imm_b, imm;
    pipe_pkg::reg_addr_t rs1, rs2;
    pipe_pkg::word_t     rs1_data, rs2_data;
    pipe_pkg::alu_op_t   alu_op;
    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic known, use_imm, write_rd, mem_read, mem_write, branch, branch_ne;

    // PC steps by one word, a taken branch overrides
    always_ff @(posedge clk_i) begin
        if (!rst_n_i)
            pc_o <= pipe_pkg::RESET_PC;
        else if (load_pc_i)
            pc_o <= pc_target_i;
        else
            pc_o <= pc_o + 32'd4;
    end

    // IF/ID, the fetched word is dropped when a branch redirects
    always_ff @(posedge clk_i) begin
        if (!rst_n_i)
            if_id_valid_o <= 1'b0;
        else
            if_id_valid_o <= instr_valid_i && !load_pc_i;
    end

    always_ff @(posedge clk_i) begin
        if_id_instr <= instr_i;
        if_id_pc    <= pc_o;
    end

    assign opcode = if_id_instr[6:0];
    assign funct3 = if_id_instr[14:12];
    assign rs1    = if_id_instr[19:15];
    assign rs2    = if_id_instr[24:20];

    // sign extended immediates
    assign imm_i = {{20{if_id_instr[31]}}, if_id_instr[31:20]};
    assign imm_s = {{20{if_id_instr[31]}}, if_id_instr[31:25], if_id_instr[11:7]};
    assign imm_b = {{19{if_id_instr[31]}}, if_id_instr[31], if_id_instr[7],
                    if_id_instr[30:25], if_id_instr[11:8], 1'b0};

    always_comb begin
        known     = 1'b0;
        alu_op    = pipe_pkg::ALU_ADD;
        use_imm   = 1'b0;
        write_rd  = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch    = 1'b0;
        branch_ne = 1'b0;
        imm       = imm_i;
        case (opcode)
            pipe_pkg::OPC_OP: begin
                known    = 1'b1;
                write_rd = 1'b1;
                case (funct3)
                    pipe_pkg::F3_ADD_SUB: alu_op = (if_id_instr[31:25] == pipe_pkg::F7_SUB) ?
                                                   pipe_pkg::ALU_SUB : pipe_pkg::ALU_ADD;
                    pipe_pkg::F3_SLT:     alu_op = pipe_pkg::ALU_SLT;
                    pipe_pkg::F3_XOR:     alu_op = pipe_pkg::ALU_XOR;
                    pipe_pkg::F3_OR:      alu_op = pipe_pkg::ALU_OR;
                    pipe_pkg::F3_AND:     alu_op = pipe_pkg::ALU_AND;
                    default:              known  = 1'b0;
                endcase
            end
            // only ADDI among the immediate ops
            pipe_pkg::OPC_OP_IMM: begin
                known    = (funct3 == pipe_pkg::F3_ADD_SUB);
                write_rd = 1'b1;
                use_imm  = 1'b1;
            end
            pipe_pkg::OPC_LOAD: begin
                known    = (funct3 == pipe_pkg::F3_WORD);
                write_rd = 1'b1;
                use_imm  = 1'b1;
                mem_read = 1'b1;
            end
            pipe_pkg::OPC_STORE: begin
                known     = (funct3 == pipe_pkg::F3_WORD);
                use_imm   = 1'b1;
                mem_write = 1'b1;
                imm       = imm_s;
            end
            // branches compare rs1 with rs2, imm only feeds the target
            pipe_pkg::OPC_BRANCH: begin
                known     = (funct3 == pipe_pkg::F3_BEQ) || (funct3 == pipe_pkg::F3_BNE);
                branch    = 1'b1;
                branch_ne = (funct3 == pipe_pkg::F3_BNE);
                imm       = imm_b;
            end
            default: known = 1'b0;
        endcase
    end

    // register file, x0 is never written
    always_ff @(posedge clk_i) begin
        if (wb_write_i && (wb_rd_i != 5'd0))
            regs[wb_rd_i] <= wb_data_i;
    end

    // write-before-read bypass from writeback
    assign rs1_data = (rs1 == 5'd0) ? '0 :
                      (wb_write_i && (wb_rd_i == rs1)) ? wb_data_i : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 :
                      (wb_write_i && (wb_rd_i == rs2)) ? wb_data_i : regs[rs2];

    // ID/EX control, flush and unknown opcodes become bubbles
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || id_ex_flush_i || !known) begin
            id_ex_valid_o     <= 1'b0;
            id_ex_write_rd_o  <= 1'b0;
            id_ex_mem_read_o  <= 1'b0;
            id_ex_mem_write_o <= 1'b0;
            id_ex_branch_o    <= 1'b0;
            id_ex_branch_ne_o <= 1'b0;
        end else begin
            id_ex_valid_o     <= 1'b1;
            id_ex_write_rd_o  <= write_rd;
            id_ex_mem_read_o  <= mem_read;
            id_ex_mem_write_o <= mem_write;
            id_ex_branch_o    <= branch;
            id_ex_branch_ne_o <= branch_ne;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk_i) begin
        id_ex_rs1_addr_o <= rs1;
        id_ex_rs2_addr_o <= rs2;
        id_ex_rs1_data_o <= rs1_data;
        id_ex_rs2_data_o <= rs2_data;
        id_ex_rd_addr_o  <= if_id_instr[11:7];
        id_ex_imm_o      <= imm;
        id_ex_pc_o       <= if_id_pc;
        id_ex_alu_op_o   <= alu_op;
        id_ex_use_imm_o  <= use_imm;
    end

endmodule : front_end_stage

`default_nettype wire

/* source/execute_stage.sv */
// operand forwarding muxes, ALU, branch resolution and EX/MEM register
`default_nettype none

module execute_stage (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                id_ex_valid_i,
    input  pipe_pkg::word_t     id_ex_rs1_data_i,
    input  pipe_pkg::word_t     id_ex_rs2_data_i,
    input  pipe_pkg::reg_addr_t id_ex_rd_addr_i,
    input  pipe_pkg::word_t     id_ex_imm_i,
    input  pipe_pkg::word_t     id_ex_pc_i,
    input  pipe_pkg::alu_op_t   id_ex_alu_op_i,
    input  logic                id_ex_use_imm_i,
    input  logic                id_ex_write_rd_i,
    input  logic                id_ex_mem_read_i,
    input  logic                id_ex_mem_write_i,
    input  logic                id_ex_branch_i,
    input  logic                id_ex_branch_ne_i,
    input  logic                fwd_ex_mem_rs1_i,
    input  logic                fwd_ex_mem_rs2_i,
    input  pipe_pkg::word_t     fwd_ex_mem_data_i,
    input  logic                fwd_mem_wb_rs1_i,
    input  logic                fwd_mem_wb_rs2_i,
    input  pipe_pkg::word_t     fwd_mem_wb_data_i,
    output logic                load_pc_o,
    output pipe_pkg::word_t     pc_target_o,
    output logic                ex_mem_valid_o,
    output pipe_pkg::reg_addr_t ex_mem_rd_addr_o,
    output logic                ex_mem_write_rd_o,
    output logic                ex_mem_mem_read_o,
    output logic                ex_mem_mem_write_o,
    output pipe_pkg::word_t     ex_mem_alu_result_o,
    output pipe_pkg::word_t     ex_mem_store_data_o
);

    pipe_pkg::word_t op_a, rs2_val, op_b, alu_result;
    logic            equal;

    // EX/MEM wins over MEM/WB, then the register value
    assign op_a = fwd_ex_mem_rs1_i ? fwd_ex_mem_data_i :
                  fwd_mem_wb_rs1_i ? fwd_mem_wb_data_i : id_ex_rs1_data_i;
    assign rs2_val = fwd_ex_mem_rs2_i ? fwd_ex_mem_data_i :
                     fwd_mem_wb_rs2_i ? fwd_mem_wb_data_i : id_ex_rs2_data_i;
    assign op_b = id_ex_use_imm_i ? id_ex_imm_i : rs2_val;

    always_comb begin
        case (id_ex_alu_op_i)
            pipe_pkg::ALU_SUB: alu_result = op_a - op_b;
            pipe_pkg::ALU_AND: alu_result = op_a & op_b;
            pipe_pkg::ALU_OR:  alu_result = op_a | op_b;
            pipe_pkg::ALU_XOR: alu_result = op_a ^ op_b;
            // signed compare
            pipe_pkg::ALU_SLT: alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            default:           alu_result = op_a + op_b;
        endcase
    end

    // branch resolves here, predicted not taken
    assign equal       = (op_a == rs2_val);
    assign load_pc_o   = id_ex_valid_i && id_ex_branch_i && (id_ex_branch_ne_i ? !equal : equal);
    assign pc_target_o = id_ex_pc_i + id_ex_imm_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ex_mem_valid_o     <= 1'b0;
            ex_mem_write_rd_o  <= 1'b0;
            ex_mem_mem_read_o  <= 1'b0;
            ex_mem_mem_write_o <= 1'b0;
        end else begin
            ex_mem_valid_o     <= id_ex_valid_i;
            ex_mem_write_rd_o  <= id_ex_write_rd_i;
            ex_mem_mem_read_o  <= id_ex_mem_read_i;
            ex_mem_mem_write_o <= id_ex_mem_write_i;
        end
    end

    // store data takes the forwarded rs2
    always_ff @(posedge clk_i) begin
        ex_mem_rd_addr_o    <= id_ex_rd_addr_i;
        ex_mem_alu_result_o <= alu_result;
        ex_mem_store_data_o <= rs2_val;
    end

endmodule : execute_stage

`default_nettype wire

/* source/memory_stage.sv */
// data memory with synchronous read and the MEM/WB register
`default_nettype none

module memory_stage (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                ex_mem_valid_i,
    input  pipe_pkg::reg_addr_t ex_mem_rd_addr_i,
    input  logic                ex_mem_write_rd_i,
    input  logic                ex_mem_mem_read_i,
    input  logic                ex_mem_mem_write_i,
    input  pipe_pkg::word_t     ex_mem_alu_result_i,
    input  pipe_pkg::word_t     ex_mem_store_data_i,
    output logic                mem_wb_valid_o,
    output pipe_pkg::reg_addr_t mem_wb_rd_addr_o,
    output logic                mem_wb_write_rd_o,
    output logic                mem_wb_use_mem_o,
    output pipe_pkg::word_t     mem_wb_alu_result_o,
    output pipe_pkg::word_t     mem_wb_dmem_rdata_o
);

    pipe_pkg::word_t             dmem [pipe_pkg::DMEM_WORDS];
    logic [pipe_pkg::DMEM_AW-1:0] addr;

    // word index from the ALU address
    assign addr = ex_mem_alu_result_i[pipe_pkg::DMEM_AW+1:2];

    // read data lands in MEM/WB alongside the ALU result
    always_ff @(posedge clk_i) begin
        if (ex_mem_valid_i && ex_mem_mem_write_i)
            dmem[addr] <= ex_mem_store_data_i;
        mem_wb_dmem_rdata_o <= dmem[addr];
        mem_wb_rd_addr_o    <= ex_mem_rd_addr_i;
        mem_wb_alu_result_o <= ex_mem_alu_result_i;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mem_wb_valid_o    <= 1'b0;
            mem_wb_write_rd_o <= 1'b0;
            mem_wb_use_mem_o  <= 1'b0;
        end else begin
            mem_wb_valid_o    <= ex_mem_valid_i;
            // writes to x0 are dropped here
            mem_wb_write_rd_o <= ex_mem_valid_i && ex_mem_write_rd_i &&
                                 (ex_mem_rd_addr_i != 5'd0);
            mem_wb_use_mem_o  <= ex_mem_mem_read_i;
        end
    end

endmodule : memory_stage

`default_nettype wire

/* source/pipe_core.sv */
// five-stage RV32I subset core, stage blocks and hazard unit
`default_nettype none

module pipe_core (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  pipe_pkg::word_t     instr_i,
    input  logic                instr_valid_i,
    output pipe_pkg::word_t     pc_o,
    output logic                wb_valid_o,
    output pipe_pkg::reg_addr_t wb_rd_o,
    output pipe_pkg::word_t     wb_data_o
);

    // ID/EX
    logic                id_ex_valid, id_ex_use_imm, id_ex_write_rd;
    logic                id_ex_mem_read, id_ex_mem_write, id_ex_branch, id_ex_branch_ne;
    pipe_pkg::reg_addr_t id_ex_rs1_addr, id_ex_rs2_addr, id_ex_rd_addr;
    pipe_pkg::word_t     id_ex_rs1_data, id_ex_rs2_data, id_ex_imm, id_ex_pc;
    pipe_pkg::alu_op_t   id_ex_alu_op;
    logic                if_id_valid;
    // EX/MEM and redirect
    logic                load_pc, ex_mem_valid, ex_mem_write_rd;
    logic                ex_mem_mem_read, ex_mem_mem_write;
    pipe_pkg::word_t     pc_target, ex_mem_alu_result, ex_mem_store_data;
    pipe_pkg::reg_addr_t ex_mem_rd_addr;
    // MEM/WB
    logic                mem_wb_valid, mem_wb_write_rd, mem_wb_use_mem;
    pipe_pkg::reg_addr_t mem_wb_rd_addr;
    pipe_pkg::word_t     mem_wb_alu_result, mem_wb_dmem_rdata;
    // forwarding and flush
    logic                fwd_ex_mem_rs1, fwd_ex_mem_rs2, fwd_mem_wb_rs1, fwd_mem_wb_rs2;
    pipe_pkg::word_t     fwd_ex_mem_data, fwd_mem_wb_data;
    logic                id_ex_flush;

    // writeback reuses the selected MEM/WB data
    assign wb_valid_o = mem_wb_valid && mem_wb_write_rd;
    assign wb_rd_o    = mem_wb_rd_addr;
    assign wb_data_o  = fwd_mem_wb_data;

    front_end_stage u_front_end (
        .clk_i, .rst_n_i, .instr_i, .instr_valid_i,
        .load_pc_i(load_pc), .pc_target_i(pc_target), .id_ex_flush_i(id_ex_flush),
        .wb_write_i(wb_valid_o), .wb_rd_i(wb_rd_o), .wb_data_i(wb_data_o), .pc_o,
        .id_ex_valid_o(id_ex_valid), .id_ex_rs1_addr_o(id_ex_rs1_addr),
        .id_ex_rs2_addr_o(id_ex_rs2_addr), .id_ex_rs1_data_o(id_ex_rs1_data),
        .id_ex_rs2_data_o(id_ex_rs2_data), .id_ex_rd_addr_o(id_ex_rd_addr),
        .id_ex_imm_o(id_ex_imm), .id_ex_pc_o(id_ex_pc), .id_ex_alu_op_o(id_ex_alu_op),
        .id_ex_use_imm_o(id_ex_use_imm), .id_ex_write_rd_o(id_ex_write_rd),
        .id_ex_mem_read_o(id_ex_mem_read), .id_ex_mem_write_o(id_ex_mem_write),
        .id_ex_branch_o(id_ex_branch), .id_ex_branch_ne_o(id_ex_branch_ne),
        .if_id_valid_o(if_id_valid)
    );

    execute_stage u_execute (
        .clk_i, .rst_n_i,
        .id_ex_valid_i(id_ex_valid), .id_ex_rs1_data_i(id_ex_rs1_data),
        .id_ex_rs2_data_i(id_ex_rs2_data), .id_ex_rd_addr_i(id_ex_rd_addr),
        .id_ex_imm_i(id_ex_imm), .id_ex_pc_i(id_ex_pc), .id_ex_alu_op_i(id_ex_alu_op),
        .id_ex_use_imm_i(id_ex_use_imm), .id_ex_write_rd_i(id_ex_write_rd),
        .id_ex_mem_read_i(id_ex_mem_read), .id_ex_mem_write_i(id_ex_mem_write),
        .id_ex_branch_i(id_ex_branch), .id_ex_branch_ne_i(id_ex_branch_ne),
        .fwd_ex_mem_rs1_i(fwd_ex_mem_rs1), .fwd_ex_mem_rs2_i(fwd_ex_mem_rs2),
        .fwd_ex_mem_data_i(fwd_ex_mem_data), .fwd_mem_wb_rs1_i(fwd_mem_wb_rs1),
        .fwd_mem_wb_rs2_i(fwd_mem_wb_rs2), .fwd_mem_wb_data_i(fwd_mem_wb_data),
        .load_pc_o(load_pc), .pc_target_o(pc_target), .ex_mem_valid_o(ex_mem_valid),
        .ex_mem_rd_addr_o(ex_mem_rd_addr), .ex_mem_write_rd_o(ex_mem_write_rd),
        .ex_mem_mem_read_o(ex_mem_mem_read), .ex_mem_mem_write_o(ex_mem_mem_write),
        .ex_mem_alu_result_o(ex_mem_alu_result), .ex_mem_store_data_o(ex_mem_store_data)
    );

    memory_stage u_memory (
        .clk_i, .rst_n_i,
        .ex_mem_valid_i(ex_mem_valid), .ex_mem_rd_addr_i(ex_mem_rd_addr),
        .ex_mem_write_rd_i(ex_mem_write_rd), .ex_mem_mem_read_i(ex_mem_mem_read),
        .ex_mem_mem_write_i(ex_mem_mem_write), .ex_mem_alu_result_i(ex_mem_alu_result),
        .ex_mem_store_data_i(ex_mem_store_data),
        .mem_wb_valid_o(mem_wb_valid), .mem_wb_rd_addr_o(mem_wb_rd_addr),
        .mem_wb_write_rd_o(mem_wb_write_rd), .mem_wb_use_mem_o(mem_wb_use_mem),
        .mem_wb_alu_result_o(mem_wb_alu_result), .mem_wb_dmem_rdata_o(mem_wb_dmem_rdata)
    );

    dep_hzrd_detection u_dep_hzrd (
        .clk_i, .rst_n_i,
        .id_ex_rs1_addr_i(id_ex_rs1_addr), .id_ex_rs2_addr_i(id_ex_rs2_addr),
        .ex_mem_rd_addr_i(ex_mem_rd_addr), .ex_mem_write_rd_i(ex_mem_write_rd),
        .ex_mem_wb_use_mem_i(ex_mem_mem_read), .ex_mem_alu_result_i(ex_mem_alu_result),
        .mem_wb_rd_addr_i(mem_wb_rd_addr), .mem_wb_write_rd_i(mem_wb_write_rd),
        .mem_wb_use_mem_i(mem_wb_use_mem), .mem_wb_alu_result_i(mem_wb_alu_result),
        .mem_wb_dmem_rdata_i(mem_wb_dmem_rdata),
        .instr_valid_i(if_id_valid), .load_pc_i(load_pc),
        .forward_ex_mem_rs1_o(fwd_ex_mem_rs1), .forward_ex_mem_rs2_o(fwd_ex_mem_rs2),
        .forward_ex_mem_data_o(fwd_ex_mem_data), .forward_mem_wb_rs1_o(fwd_mem_wb_rs1),
        .forward_mem_wb_rs2_o(fwd_mem_wb_rs2), .forward_mem_wb_data_o(fwd_mem_wb_data),
        .id_ex_flush_o(id_ex_flush)
    );

endmodule : pipe_core

`default_nettype wire

/* dv/pipe_core_tb.sv */
// pipe_core testbench with clock, reset, instruction memory model,
// golden file reader, writeback checker and watchdog
`default_nettype none

module pipe_core_tb;

    localparam int          GOLDEN_WORDS = 512;
    localparam int          MAX_TESTS    = 16;
    // ADDI x0, x0, 0
    localparam logic [31:0] NOP          = 32'h00000013;
    // ADDI x31, x0, 2047, shows up on writeback if an empty slot is decoded
    localparam logic [31:0] POISON       = 32'h7ff00f93;

    logic                clk_i;
    logic                rst_n_i;
    pipe_pkg::word_t     instr_i;
    logic                instr_valid_i;
    pipe_pkg::word_t     pc_o;
    logic                wb_valid_o;
    pipe_pkg::reg_addr_t wb_rd_o;
    pipe_pkg::word_t     wb_data_o;

    // raw golden image and per test offsets into it
    logic [31:0] golden [GOLDEN_WORDS];
    int          test_count;
    int          test_id   [MAX_TESTS];
    int          prog_base [MAX_TESTS];
    int          prog_len  [MAX_TESTS];
    int          wb_base   [MAX_TESTS];
    int          wb_count  [MAX_TESTS];
    logic        bubbles   [MAX_TESTS];

    int   errors;
    int   checks;
    int   wb_seen;
    int   watchdog_limit;
    logic parsed;

    pipe_core UUT (
        .clk_i(clk_i),
        .rst_n_i(rst_n_i),
        .instr_i(instr_i),
        .instr_valid_i(instr_valid_i),
        .pc_o(pc_o),
        .wb_valid_o(wb_valid_o),
        .wb_rd_o(wb_rd_o),
        .wb_data_o(wb_data_o)
    );

    // 40 unit period
    always #20 clk_i = ~clk_i;

    function automatic string test_name(input int id);
        case (id)
            1: return "alu_independent";
            2: return "forwarding_chain";
            3: return "store_load";
            4: return "branches";
            5: return "x0_writes";
            6: return "valid_bubbles";
            default: return "unknown_test";
        endcase
    endfunction

    // walks the records, test_count is already known to be in range
    task automatic index_golden();
        int pos;
        int t;
        pos = 1;
        for (t = 0; t < test_count; t++) begin
            test_id[t]   = int'(golden[pos]);
            prog_len[t]  = int'(golden[pos + 1]);
            prog_base[t] = pos + 2;
            pos          = pos + 2 + prog_len[t];
            wb_count[t]  = int'(golden[pos]);
            wb_base[t]   = pos + 1;
            pos          = pos + 1 + 2 * wb_count[t];
            bubbles[t]   = golden[pos][0];
            pos          = pos + 1;
        end
    endtask

    // instruction memory answers the current pc in the same cycle
    task automatic drive_fetch(input int t);
        int              idx;
        int unsigned     roll;
        pipe_pkg::word_t word;
        idx  = int'(pc_o >> 2);
        roll = $urandom;
        if (idx < prog_len[t])
            word = golden[prog_base[t] + idx];
        else
            word = NOP;
        instr_i       = word;
        instr_valid_i = 1'b1;
        // a nop slot may go empty, the pc still steps past it
        // and the word left on the bus must be ignored
        if (bubbles[t] && (word == NOP) && (roll % 3 == 0)) begin
            instr_valid_i = 1'b0;
            instr_i       = POISON;
        end
    endtask

    // compares one retiring write with the next expected pair
    task automatic check_writeback(input int t);
        int                  base;
        pipe_pkg::reg_addr_t exp_rd;
        pipe_pkg::word_t     exp_data;
        if (wb_valid_o) begin
            if (wb_seen >= wb_count[t]) begin
                errors++;
                $display("ERROR: %s retired an unexpected write x%0d = %08h",
                         test_name(test_id[t]), wb_rd_o, wb_data_o);
            end else begin
                base     = wb_base[t] + 2 * wb_seen;
                exp_rd   = golden[base][4:0];
                exp_data = golden[base + 1];
                checks++;
                if ((wb_rd_o !== exp_rd) || (wb_data_o !== exp_data)) begin
                    errors++;
                    $display("CHECK FAILED %s write %0d: expected x%0d=%08h, actual x%0d=%08h",
                             test_name(test_id[t]), wb_seen, exp_rd, exp_data,
                             wb_rd_o, wb_data_o);
                end
            end
            wb_seen++;
        end
    endtask

    task automatic run_test(input int t);
        wb_seen = 0;
        rst_n_i = 1'b0;
        drive_fetch(t);
        repeat (3) begin
            @(negedge clk_i);
            drive_fetch(t);
        end
        // first fetch after reset comes from the reset vector
        checks++;
        if (pc_o !== pipe_pkg::RESET_PC) begin
            errors++;
            $display("CHECK FAILED %s reset pc: expected %08h, actual %08h",
                     test_name(test_id[t]), pipe_pkg::RESET_PC, pc_o);
        end
        rst_n_i = 1'b1;
        while (wb_seen < wb_count[t]) begin
            @(negedge clk_i);
            check_writeback(t);
            drive_fetch(t);
        end
        // drain, anything late or extra still shows up here
        repeat (prog_len[t] + 4) begin
            @(negedge clk_i);
            check_writeback(t);
            drive_fetch(t);
        end
    endtask

    initial begin
        int t;
        clk_i          = 1'b0;
        rst_n_i        = 1'b0;
        instr_i        = NOP;
        instr_valid_i  = 1'b0;
        errors         = 0;
        checks         = 0;
        wb_seen        = 0;
        watchdog_limit = 0;
        parsed         = 1'b0;
        void'($urandom(32'h436b));
        $readmemh("dv/pipe_core_golden.txt", golden);
        test_count = int'(golden[0]);
        if ((test_count < 1) || (test_count > MAX_TESTS)) begin
            errors++;
            $display("ERROR: golden file gives %0d tests, the testbench takes 1 to %0d",
                     test_count, MAX_TESTS);
        end else begin
            index_golden();
            for (t = 0; t < test_count; t++)
                watchdog_limit += (prog_len[t] + wb_count[t] + 20) * 40 * 2;
            parsed = 1'b1;
            for (t = 0; t < test_count; t++)
                run_test(t);
        end
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    // budget grows with program length and writeback count
    initial begin
        wait (parsed);
        #(watchdog_limit);
        $display("ERROR: watchdog expired after %0d time units, writebacks stopped coming",
                 watchdog_limit);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* pipe_core.f */
source/pipe_pkg.sv
source/dep_hzrd_detection.sv
source/front_end_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/pipe_core.sv
dv/pipe_core_tb.sv

/* Makefile */
# Verilator build and run for the pipe_core testbench
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := pipe_core_tb
FILELIST  := pipe_core.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))
GOLDEN    := dv/pipe_core_golden.txt

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN) $(GOLDEN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/pipe_core_golden.txt */
// first word: number of tests; each test: id, program length, program words,
// writeback count, (rd data) pairs, bubble flag
6

// independent register and immediate ALU operations
1 0f
06400093 ff900113 5a500193 0f000213 00000013 00000013 00000013 002082b3
40208333 0041f3b3 0041e433 0041c4b3 00112533 0020a5b3 f9c10613
0c
01 00000064  02 fffffff9  03 000005a5  04 000000f0  05 0000005d  06 0000006b
07 000000a0  08 000005f5  09 00000555  0a 00000001  0b 00000000  0c ffffff95
0

// EX/MEM, MEM/WB and register file forwarding, triple chain on x6
2 0c
00500093 00308113 002081b3 00308233 00100313 00200313 00300313 006303b3
00734433 406404b3 00906533 009505b3
0c
01 00000005  02 00000008  03 0000000d  04 00000012  06 00000001  06 00000002
06 00000003  07 00000006  08 00000005  09 00000002  0a 00000002  0b 00000004
0

// stores, loads and loaded data forwarded from MEM/WB
3 0d
12300093 01000113 00112223 ffe00193 00312423 00412203 00812283 00020333
006283b3 00712023 00012403 00000013 00140493
09
01 00000123  02 00000010  03 fffffffe  04 00000123  05 fffffffe  06 00000123
07 00000121  08 00000121  09 00000122
0

// taken BEQ and BNE skip the shadow, not taken branches skip nothing
4 10
00700093 00700113 00208663 00100193 00100213 05500293 00209663 06600313
07700393 00629863 00100413 00100493 00100513 007285b3 00508463 01200613
07
01 00000007  02 00000007  05 00000055  06 00000066  07 00000077  0b 000000cc
0c 00000012
0

// writes to x0 neither retire nor forward
5 06
00900093 00500013 00100133 00108033 000001b3 40010233
04
01 00000009  02 00000009  03 00000000  04 00000009
0

// random empty fetch slots in place of nops
6 10
03100093 00000013 01008113 00000013 00000013 00202023 00002183 00000013
00118233 00021663 00100293 00100313 00000013 002243b3 00000013 fff38413
06
01 00000031  02 00000041  03 00000041  04 00000072  07 00000033  08 00000032
1
